// File: ramio_pkg.sv
// ramio shared definitions
// data widths, load/store type codes and the cache FSM states
package ramio_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0] byte_t;
  typedef logic [63:0] line_t;
  typedef logic [3:0] byte_en_t;

  // bit 2 flags sign extension, bits 1:0 give the size, 0 is no read
  typedef logic [2:0] read_type_t;
  // 0 is no write
  typedef logic [1:0] write_type_t;

  // size codes, compared against read_type[1:0] and write_type
  localparam logic [1:0] rt_byte = 2'b01;
  localparam logic [1:0] rt_half = 2'b10;
  localparam logic [1:0] rt_word = 2'b11;
  localparam write_type_t wt_byte = 2'b01;
  localparam write_type_t wt_half = 2'b10;
  localparam write_type_t wt_word = 2'b11;

  typedef enum logic [1:0] {idle, fill_wait, write} cache_state_e;

endpackage

// File: uarttx.sv
// uart transmitter, 8 data bits, no parity, one stop bit
// starts a frame on go, holds bsy for the frame, then waits for go to drop
`timescale 1ns/1ps
`default_nettype none

module uarttx import ramio_pkg::*; #(
  parameter int unsigned clock_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input wire clk,
  input wire rst_n,
  input wire byte_t data,
  input wire go,
  output logic tx,
  output logic bsy
);

  localparam int unsigned bit_clks = clock_hz / baud_rate;
  localparam int unsigned cnt_width = $clog2(bit_clks + 1);

  // clocks spent in the current bit
  logic [cnt_width-1:0] clk_cnt;
  // 0 is the start bit, 1..8 data, 9 stop
  logic [3:0] bit_cnt;
  // remaining data bits and the stop bit, lsb goes out next
  logic [8:0] shift;
  // frame sent, go still high
  logic done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx <= 1'b1;
      bsy <= 1'b0;
      done <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shift <= '1;
    end else if (done) begin
      // client acknowledges by dropping go
      if (!go) done <= 1'b0;
    end else if (!bsy) begin
      if (go) begin
        // latch the byte and drive the start bit right away
        shift <= {1'b1, data};
        tx <= 1'b0;
        bsy <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == cnt_width'(bit_clks - 1)) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // stop bit done, line stays high
        bsy <= 1'b0;
        done <= 1'b1;
      end else begin
        tx <= shift[0];
        shift <= {1'b1, shift[8:1]};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: uartrx.sv
// uart receiver, 8 data bits, no parity, one stop bit
// samples mid-bit and holds data_ready until go drops
`timescale 1ns/1ps
`default_nettype none

module uartrx import ramio_pkg::*; #(
  parameter int unsigned clock_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200
) (
  input wire clk,
  input wire rst_n,
  input wire go,
  input wire rx,
  output byte_t data,
  output logic data_ready
);

  localparam int unsigned bit_clks = clock_hz / baud_rate;
  localparam int unsigned half_clks = bit_clks / 2;
  localparam int unsigned cnt_width = $clog2(bit_clks + 1);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_e;

  rx_state_e state;
  // two-flop synchroniser on the serial line
  logic rx_meta;
  logic rx_sync;
  logic [cnt_width-1:0] clk_cnt;
  logic [2:0] bit_idx;
  byte_t shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rx_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      shift <= '0;
      data <= '0;
      data_ready <= 1'b0;
    end else begin
      // acknowledge from the client
      if (!go) data_ready <= 1'b0;

      unique case (state)
        rx_idle: begin
          // falling edge starts a frame
          if (!rx_sync) begin
            state <= rx_start;
            clk_cnt <= '0;
          end
        end
        rx_start: begin
          if (clk_cnt == cnt_width'(half_clks - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // glitch shorter than half a bit goes back to idle
            state <= rx_sync ? rx_idle : rx_bits;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_bits: begin
          if (clk_cnt == cnt_width'(bit_clks - 1)) begin
            clk_cnt <= '0;
            // lsb first
            shift <= {rx_sync, shift[7:1]};
            if (bit_idx == 3'd7) state <= rx_stop;
            else bit_idx <= bit_idx + 3'd1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (clk_cnt == cnt_width'(bit_clks - 1)) begin
            clk_cnt <= '0;
            state <= rx_idle;
            // framing error drops the byte
            if (rx_sync) begin
              data <= shift;
              data_ready <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cache.sv
// direct-mapped write-through cache
// 32-bit byte-enabled client port, one 64-bit burst word per line
// misses fill from burst ram, writes allocate and go through as whole lines
`timescale 1ns/1ps
`default_nettype none

module cache import ramio_pkg::*; #(
  parameter int unsigned ram_addr_width = 10,
  parameter int unsigned line_index_width = 2
) (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire addr_t address,
  input wire data_t data_in,
  input wire byte_en_t write_enable,
  output data_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output logic [ram_addr_width-1:0] br_addr,
  output line_t br_wr_data,
  output logic [7:0] br_data_mask,
  input wire line_t br_rd_data,
  input wire br_rd_data_valid
);

  localparam int unsigned num_lines = 2 ** line_index_width;
  localparam int unsigned tag_width = ram_addr_width - line_index_width;

  line_t lines [num_lines];
  logic [tag_width-1:0] tags [num_lines];
  logic [num_lines-1:0] valid;
  cache_state_e state;

  // double-word address in burst ram, split into tag and index
  logic [ram_addr_width-1:0] line_addr;
  logic [line_index_width-1:0] index;
  logic [tag_width-1:0] tag;
  line_t cur_line;
  line_t merged;
  logic hit;
  logic is_write;
  logic miss_start;
  logic write_hit;
  logic fill_done;

  assign line_addr = address[ram_addr_width+2:3];
  assign index = line_addr[line_index_width-1:0];
  assign tag = line_addr[ram_addr_width-1:line_index_width];
  assign cur_line = lines[index];
  assign hit = valid[index] && (tags[index] == tag);
  assign is_write = (write_enable != '0);

  assign miss_start = (state == idle) && enable && !hit;
  assign write_hit = (state == idle) && enable && hit && is_write;
  assign fill_done = (state == fill_wait) && br_rd_data_valid;

  // address bit 2 picks the word within the line
  assign data_out = address[2] ? cur_line[63:32] : cur_line[31:0];

  // whole lines are written
  assign br_data_mask = '0;

  // merge enabled bytes into the selected word of the line
  always_comb begin
    merged = cur_line;
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) merged[32 * address[2] + 8 * i +: 8] = data_in[8 * i +: 8];
    end
  end

  always_comb begin
    data_out_ready = 1'b0;
    busy = 1'b0;
    unique case (state)
      idle: begin
        if (enable) begin
          // read hit completes now, everything else stalls
          if (hit && !is_write) data_out_ready = 1'b1;
          else busy = 1'b1;
        end
      end
      fill_wait: busy = 1'b1;
      // write command is on the bus this cycle
      write: data_out_ready = enable;
      default: busy = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      valid <= '0;
      br_cmd_en <= 1'b0;
    end else begin
      // commands are single-cycle pulses
      br_cmd_en <= 1'b0;
      unique case (state)
        idle: begin
          if (miss_start) begin
            // write misses also fill first, then retry as a hit
            state <= fill_wait;
            br_cmd_en <= 1'b1;
          end else if (write_hit) begin
            state <= write;
            br_cmd_en <= 1'b1;
          end
        end
        fill_wait: begin
          if (br_rd_data_valid) begin
            valid[index] <= 1'b1;
            state <= idle;
          end
        end
        write: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // line storage and command payload
  always_ff @(posedge clk) begin
    if (miss_start) begin
      br_cmd <= 1'b0;
      br_addr <= line_addr;
    end
    if (write_hit) begin
      br_cmd <= 1'b1;
      br_addr <= line_addr;
      br_wr_data <= merged;
      lines[index] <= merged;
    end
    if (fill_done) begin
      lines[index] <= br_rd_data;
      tags[index] <= tag;
    end
  end

endmodule

`default_nettype wire

// File: ramio.sv
// load/store front end for the soft processor
// sends memory accesses to the cache and maps the top three
// addresses to the led register and the uart transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module ramio import ramio_pkg::*; #(
  parameter int unsigned ram_addr_width = 10,
  parameter addr_t top_address = '1
) (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire read_type_t read_type,
  input wire write_type_t write_type,
  input wire addr_t address,
  input wire data_t data_in,
  output data_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output logic cache_enable,
  output addr_t cache_address,
  output data_t cache_data_in,
  output byte_en_t cache_write_enable,
  input wire data_t cache_data_out,
  input wire cache_data_out_ready,
  input wire cache_busy,
  output byte_t tx_data,
  output logic tx_go,
  input wire tx_bsy,
  input wire byte_t rx_data,
  input wire rx_data_ready,
  output logic rx_go
);

  localparam addr_t addr_led = top_address;
  localparam addr_t addr_uart_out = top_address - 1;
  localparam addr_t addr_uart_in = top_address - 2;

  logic is_io;
  logic led_write;
  logic tx_write;
  logic rx_read;
  // byte handed to the transmitter
  byte_t tx_byte;
  // transmitter busy one cycle ago, for the falling edge
  logic tx_bsy_q;
  // last received byte, cleared when read
  byte_t rx_byte;
  byte_t sel_byte;
  logic [15:0] sel_half;
  logic sign;

  assign is_io = (address == addr_led) || (address == addr_uart_out) ||
                 (address == addr_uart_in);

  // i/o is registers only, never stalls
  assign busy = is_io ? 1'b0 : cache_busy;
  assign data_out_ready = is_io ? 1'b1 : cache_data_out_ready;

  // i/o registers take byte accesses only
  assign led_write = enable && (address == addr_led) && (write_type == wt_byte);
  assign tx_write = enable && (address == addr_uart_out) && (write_type == wt_byte);
  assign rx_read = enable && (address == addr_uart_in) && (read_type[1:0] == rt_byte);

  assign tx_data = tx_byte;
  assign sign = read_type[2];

  // store side: word-aligned address, data replicated, lanes picked by enables
  always_comb begin
    cache_enable = enable && !is_io;
    // upper bits beyond the ram are dropped
    cache_address = addr_t'({address[ram_addr_width+2:2], 2'b00});
    cache_write_enable = '0;
    cache_data_in = '0;
    if (cache_enable) begin
      case (write_type)
        wt_byte: begin
          cache_write_enable = byte_en_t'(4'b0001 << address[1:0]);
          cache_data_in = {4{data_in[7:0]}};
        end
        wt_half: begin
          // odd address is ignored
          if (!address[0]) begin
            cache_write_enable = address[1] ? 4'b1100 : 4'b0011;
            cache_data_in = {2{data_in[15:0]}};
          end
        end
        wt_word: begin
          if (address[1:0] == 2'b00) begin
            cache_write_enable = 4'b1111;
            cache_data_in = data_in;
          end
        end
        default: cache_write_enable = '0;
      endcase
    end
  end

  // load side: pick the lane, then sign or zero extend
  always_comb begin
    sel_byte = cache_data_out[{address[1:0], 3'b000} +: 8];
    sel_half = cache_data_out[{address[1], 4'b0000} +: 16];
    if (address == addr_uart_in) sel_byte = rx_byte;
    else if (address == addr_uart_out) sel_byte = tx_byte;
    else if (address == addr_led) sel_byte = {4'b0000, led};

    data_out = '0;
    if (enable) begin
      case (read_type[1:0])
        rt_byte: data_out = {{24{sign & sel_byte[7]}}, sel_byte};
        rt_half: begin
          if (!address[0] && !is_io) data_out = {{16{sign & sel_half[15]}}, sel_half};
        end
        rt_word: begin
          if (address[1:0] == 2'b00 && !is_io) data_out = cache_data_out;
        end
        default: data_out = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // leds are active low, all off
      led <= 4'b1111;
      tx_byte <= '0;
      tx_go <= 1'b0;
      tx_bsy_q <= 1'b0;
      rx_byte <= '0;
      rx_go <= 1'b1;
    end else begin
      // a read wins, a pending byte is picked up next cycle
      if (rx_read) begin
        rx_byte <= '0;
      end else if (rx_go && rx_data_ready) begin
        // copy and acknowledge, may overrun an unread byte
        rx_byte <= rx_data;
        rx_go <= 1'b0;
      end

      // go low for one cycle only
      if (!rx_go) rx_go <= 1'b1;

      tx_bsy_q <= tx_bsy;
      // frame finished, bsy has just fallen
      if (tx_go && tx_bsy_q && !tx_bsy) begin
        tx_go <= 1'b0;
        tx_byte <= '0;
      end

      // a new byte replaces any pending one
      if (tx_write) begin
        tx_byte <= data_in[7:0];
        tx_go <= 1'b1;
      end

      if (led_write) led <= data_in[3:0];
    end
  end

endmodule

`default_nettype wire

// File: burst_ram.sv
// behavioural 64-bit burst ram model
// one word per command, read data valid a fixed 4 cycles after the command
`timescale 1ns/1ps
`default_nettype none

module burst_ram import ramio_pkg::*; #(
  parameter int unsigned ram_addr_width = 10
) (
  input wire clk,
  input wire rst_n,
  // 0 read, 1 write
  input wire cmd,
  input wire cmd_en,
  input wire [ram_addr_width-1:0] addr,
  input wire line_t wr_data,
  // a set bit masks its byte off the write
  input wire [7:0] data_mask,
  output line_t rd_data,
  output logic rd_data_valid
);

  localparam int unsigned latency = 4;
  localparam int unsigned depth = 2 ** ram_addr_width;

  line_t mem [depth];
  line_t rd_pipe [latency];
  logic [latency-1:0] valid_pipe;

  initial begin
    for (int i = 0; i < depth; i++) mem[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (cmd_en && cmd) begin
      for (int i = 0; i < 8; i++) begin
        if (!data_mask[i]) mem[addr][8 * i +: 8] <= wr_data[8 * i +: 8];
      end
    end
    // data shifts every cycle, valid marks the real reads
    rd_pipe[0] <= mem[addr];
    for (int i = 1; i < latency; i++) rd_pipe[i] <= rd_pipe[i - 1];
  end

  // several reads may be in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) valid_pipe <= '0;
    else valid_pipe <= {valid_pipe[latency-2:0], cmd_en && !cmd};
  end

  assign rd_data = rd_pipe[latency-1];
  assign rd_data_valid = valid_pipe[latency-1];

endmodule

`default_nettype wire

// File: ramio_top.sv
// memory and i/o subsystem for the soft processor
// ramio front end, cache, uart pair and the burst ram model
`timescale 1ns/1ps
`default_nettype none

module ramio_top import ramio_pkg::*; #(
  parameter int unsigned ram_addr_width = 10,
  parameter int unsigned line_index_width = 2,
  parameter int unsigned clock_hz = 50_000_000,
  parameter int unsigned baud_rate = 115_200,
  parameter addr_t top_address = '1
) (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire read_type_t read_type,
  input wire write_type_t write_type,
  input wire addr_t address,
  input wire data_t data_in,
  output data_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output logic uart_tx,
  input wire uart_rx
);

  logic cache_enable;
  addr_t cache_address;
  data_t cache_data_in;
  byte_en_t cache_write_enable;
  data_t cache_data_out;
  logic cache_data_out_ready;
  logic cache_busy;

  byte_t tx_data;
  logic tx_go;
  logic tx_bsy;
  byte_t rx_data;
  logic rx_data_ready;
  logic rx_go;

  // burst ram bus
  logic br_cmd;
  logic br_cmd_en;
  logic [ram_addr_width-1:0] br_addr;
  line_t br_wr_data;
  logic [7:0] br_data_mask;
  line_t br_rd_data;
  logic br_rd_data_valid;

  ramio #(
    .ram_addr_width(ram_addr_width),
    .top_address(top_address)
  ) ramio_inst (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .read_type(read_type),
    .write_type(write_type),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .led(led),
    .cache_enable(cache_enable),
    .cache_address(cache_address),
    .cache_data_in(cache_data_in),
    .cache_write_enable(cache_write_enable),
    .cache_data_out(cache_data_out),
    .cache_data_out_ready(cache_data_out_ready),
    .cache_busy(cache_busy),
    .tx_data(tx_data),
    .tx_go(tx_go),
    .tx_bsy(tx_bsy),
    .rx_data(rx_data),
    .rx_data_ready(rx_data_ready),
    .rx_go(rx_go)
  );

  cache #(
    .ram_addr_width(ram_addr_width),
    .line_index_width(line_index_width)
  ) cache_inst (
    .clk(clk),
    .rst_n(rst_n),
    .enable(cache_enable),
    .address(cache_address),
    .data_in(cache_data_in),
    .write_enable(cache_write_enable),
    .data_out(cache_data_out),
    .data_out_ready(cache_data_out_ready),
    .busy(cache_busy),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_data_mask(br_data_mask),
    .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  uarttx #(
    .clock_hz(clock_hz),
    .baud_rate(baud_rate)
  ) uarttx_inst (
    .clk(clk),
    .rst_n(rst_n),
    .data(tx_data),
    .go(tx_go),
    .tx(uart_tx),
    .bsy(tx_bsy)
  );

  uartrx #(
    .clock_hz(clock_hz),
    .baud_rate(baud_rate)
  ) uartrx_inst (
    .clk(clk),
    .rst_n(rst_n),
    .go(rx_go),
    .rx(uart_rx),
    .data(rx_data),
    .data_ready(rx_data_ready)
  );

  burst_ram #(
    .ram_addr_width(ram_addr_width)
  ) burst_ram_inst (
    .clk(clk),
    .rst_n(rst_n),
    .cmd(br_cmd),
    .cmd_en(br_cmd_en),
    .addr(br_addr),
    .wr_data(br_wr_data),
    .data_mask(br_data_mask),
    .rd_data(br_rd_data),
    .rd_data_valid(br_rd_data_valid)
  );

endmodule

`default_nettype wire

// File: ramio_top_props.sv
// bound checks on the ramio front end and the cache command bus
// attached to ramio_top so both client and burst ram sides are visible
`timescale 1ns/1ps
`default_nettype none

module ramio_top_props import ramio_pkg::*; (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire data_t data_out,
  input wire byte_en_t cache_write_enable,
  input wire br_cmd,
  input wire br_cmd_en,
  input wire br_rd_data_valid
);

  // a read command comes back exactly four cycles later
  read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (br_cmd_en && !br_cmd) |-> ##4 br_rd_data_valid)
    else $error("burst ram read data not valid four cycles after the command");

  // commands are one-cycle pulses
  cmd_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en high for two cycles");

  // single byte, aligned half, whole word or nothing
  legal_lanes: assert property (@(posedge clk) disable iff (!rst_n)
    cache_write_enable inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                               4'b0011, 4'b1100, 4'b1111})
    else $error("illegal cache byte enable pattern %b", cache_write_enable);

  idle_output_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |-> data_out == '0)
    else $error("data_out not zero while enable is low");

endmodule

bind ramio_top ramio_top_props ramio_top_props_inst (
  .clk(clk),
  .rst_n(rst_n),
  .enable(enable),
  .data_out(data_out),
  .cache_write_enable(cache_write_enable),
  .br_cmd(br_cmd),
  .br_cmd_en(br_cmd_en),
  .br_rd_data_valid(br_rd_data_valid)
);

`default_nettype wire

// File: ramio_top_tb.sv
// testbench for the ramio memory and i/o subsystem
// replays load/store requests from the stimulus file against a byte model,
// decodes frames on uart_tx and drives bytes into uart_rx
`timescale 1ns/1ps
`default_nettype none

module ramio_top_tb;
  import ramio_pkg::*;

  localparam int ram_addr_width = 10;
  localparam int mem_bytes = 8 << ram_addr_width;
  // 1 MHz clock, 100 kbaud
  localparam int bit_clks = 10;
  localparam addr_t addr_led = 32'hffff_ffff;
  localparam addr_t addr_uart_out = 32'hffff_fffe;
  localparam addr_t addr_uart_in = 32'hffff_fffd;

  logic clk;
  logic rst_n;
  logic enable;
  read_type_t read_type;
  write_type_t write_type;
  addr_t address;
  data_t data_in;
  data_t data_out;
  logic data_out_ready;
  logic busy;
  logic [3:0] led;
  logic uart_tx;
  logic uart_rx;

  int errors = 0;
  int seed = 73;
  int num_reqs = 0;

  // stimulus columns
  logic [3:0] op_q [$];
  logic [2:0] typ_q [$];
  addr_t addr_q [$];
  data_t data_q [$];
  data_t exp_q [$];

  // reference model state
  byte_t ref_mem [mem_bytes];
  logic [3:0] led_model = 4'hf;
  byte_t rx_model = '0;
  byte_t tx_expect [$];
  // bytes seen on uart_tx
  byte_t tx_frames [$];

  ramio_top #(
    .ram_addr_width(ram_addr_width),
    .line_index_width(2),
    .clock_hz(1000000),
    .baud_rate(100000),
    .top_address(addr_led)
  ) ramio_top_inst (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .read_type(read_type),
    .write_type(write_type),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .led(led),
    .uart_tx(uart_tx),
    .uart_rx(uart_rx)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic is_io_addr(input addr_t a);
    return (a == addr_led) || (a == addr_uart_out) || (a == addr_uart_in);
  endfunction

  function automatic data_t extend_load(input data_t raw, input logic [1:0] size,
                                        input logic sgn);
    case (size)
      rt_byte: return {{24{sgn & raw[7]}}, raw[7:0]};
      rt_half: return {{16{sgn & raw[15]}}, raw[15:0]};
      rt_word: return raw;
      default: return '0;
    endcase
  endfunction

  // value a load should return, from the byte model
  function automatic data_t expected_load(input addr_t a, input read_type_t rt);
    data_t raw;
    int base;
    raw = '0;
    base = int'(a[ram_addr_width+2:0]) & ~3;
    if (is_io_addr(a)) begin
      // i/o answers byte loads only, uart out reads as zero once idle
      if (rt[1:0] != rt_byte) return '0;
      if (a == addr_led) raw = {28'b0, led_model};
      else if (a == addr_uart_in) raw = {24'b0, rx_model};
      return extend_load(raw, rt_byte, rt[2]);
    end
    // misaligned loads give zero
    if (rt[1:0] == rt_half && a[0]) return '0;
    if (rt[1:0] == rt_word && a[1:0] != 2'b00) return '0;
    for (int k = 0; k < 4; k++) raw[8*k +: 8] = ref_mem[base + k];
    if (rt[1:0] == rt_byte) raw = raw >> (8 * a[1:0]);
    if (rt[1:0] == rt_half) raw = raw >> (16 * a[1]);
    return extend_load(raw, rt[1:0], rt[2]);
  endfunction

  function automatic void apply_store(input addr_t a, input write_type_t wt, input data_t d);
    int idx;
    idx = int'(a[ram_addr_width+2:0]);
    if (is_io_addr(a)) begin
      if (wt == wt_byte && a == addr_led) led_model = d[3:0];
      if (wt == wt_byte && a == addr_uart_out) tx_expect.push_back(d[7:0]);
    end else begin
      case (wt)
        wt_byte: ref_mem[idx] = d[7:0];
        wt_half: begin
          if (!a[0]) begin
            ref_mem[idx] = d[7:0];
            ref_mem[idx + 1] = d[15:8];
          end
        end
        wt_word: begin
          if (a[1:0] == 2'b00) begin
            for (int k = 0; k < 4; k++) ref_mem[idx + k] = d[8*k +: 8];
          end
        end
        default: idx = 0;
      endcase
    end
  endfunction

  task automatic load_stimulus();
    int fd;
    int n;
    string line;
    logic [31:0] f_op;
    logic [31:0] f_typ;
    addr_t f_addr;
    data_t f_data;
    data_t f_exp;
    fd = $fopen("ramio_top_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file ramio_top_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank and comment lines
        if (n > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h %h", f_op, f_typ, f_addr, f_data, f_exp) == 5) begin
            op_q.push_back(f_op[3:0]);
            typ_q.push_back(f_typ[2:0]);
            addr_q.push_back(f_addr);
            data_q.push_back(f_data);
            exp_q.push_back(f_exp);
          end else begin
            errors++;
            $display("malformed stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    num_reqs = op_q.size();
  endtask

  // present one request and hold it until busy low with ready high
  task automatic issue_request(input logic is_wr, input logic [2:0] typ, input addr_t a,
                               input data_t d, output data_t result);
    int cycles;
    cycles = 0;
    @(posedge clk);
    enable <= 1'b1;
    address <= a;
    data_in <= d;
    read_type <= is_wr ? 3'b000 : typ;
    write_type <= is_wr ? typ[1:0] : 2'b00;
    @(negedge clk);
    while ((busy || !data_out_ready) && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= 100) begin
      errors++;
      $display("request to address %h never completed", a);
    end
    result = data_out;
    // the request ends at this edge
    @(posedge clk);
    enable <= 1'b0;
    read_type <= '0;
    write_type <= '0;
  endtask

  // one 8N1 frame into the receiver, then a bit time of idle line
  task automatic send_serial(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      uart_rx <= frame[i];
      repeat (bit_clks) @(posedge clk);
    end
    repeat (bit_clks) @(posedge clk);
  endtask

  task automatic execute_line(input logic [3:0] op, input logic [2:0] typ, input addr_t a,
                              input data_t d, input data_t exp);
    data_t result;
    data_t expected;
    byte_t frame;
    int waited;
    case (op)
      // store
      4'h0: begin
        apply_store(a, typ[1:0], d);
        issue_request(1'b1, typ, a, d, result);
        if (a == addr_led) begin
          @(negedge clk);
          check_value({28'b0, led}, {28'b0, led_model}, "led port after store");
        end
      end
      // load, file value cross-checked against the model
      4'h1: begin
        expected = expected_load(a, typ);
        check_value(exp, expected, $sformatf("stimulus value for load of %h", a));
        issue_request(1'b0, typ, a, d, result);
        check_value(result, expected, $sformatf("load of %h type %0d", a, typ));
        // receive register clears on a byte load
        if (a == addr_uart_in && typ[1:0] == rt_byte) rx_model = '0;
      end
      // frame expected on uart_tx
      4'h2: begin
        waited = 0;
        while (tx_frames.size() == 0 && waited < 20 * bit_clks) begin
          @(negedge clk);
          waited++;
        end
        if (tx_frames.size() == 0 || tx_expect.size() == 0) begin
          errors++;
          $display("no frame on uart_tx where one was expected");
        end else begin
          frame = tx_frames.pop_front();
          expected = {24'b0, tx_expect.pop_front()};
          check_value(exp, expected, "stimulus value for uart_tx frame");
          check_value({24'b0, frame}, expected, "byte decoded from uart_tx");
        end
      end
      // byte into uart_rx
      4'h3: begin
        send_serial(d[7:0]);
        rx_model = d[7:0];
      end
      default: begin
        errors++;
        $display("unknown operation %h in the stimulus file", op);
      end
    endcase
  endtask

  // serial decoder, samples each bit near its middle
  initial begin : tx_decoder
    byte_t b;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && uart_tx === 1'b0) begin
        repeat (bit_clks / 2 - 1) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (bit_clks) @(negedge clk);
          b[i] = uart_tx;
        end
        repeat (bit_clks) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          errors++;
          $display("missing stop bit on uart_tx");
        end
        tx_frames.push_back(b);
      end
    end
  end

  initial begin : watchdog
    int limit;
    @(posedge clk);
    limit = (num_reqs + 1) * 2000;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    int gap;
    rst_n = 1'b0;
    enable = 1'b0;
    read_type = '0;
    write_type = '0;
    address = '0;
    data_in = '0;
    uart_rx = 1'b1;
    for (int i = 0; i < mem_bytes; i++) ref_mem[i] = '0;
    load_stimulus();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value({28'b0, led}, 32'h0000_000f, "led port after reset");
    for (int i = 0; i < num_reqs; i++) begin
      // random idle gap between requests
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      execute_line(op_q[i], typ_q[i], addr_q[i], data_q[i], exp_q[i]);
    end
    repeat (5) @(posedge clk);
    if (tx_frames.size() != 0) begin
      errors++;
      $display("%0d unexpected frames on uart_tx", tx_frames.size());
    end
    $display("%0d requests run, %0d errors", num_reqs, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ramio_top_stimulus.txt
# columns in hex: operation type address data expected
# operation 0 store, 1 load, 2 frame expected on uart_tx, 3 byte sent into uart_rx
1 1 ffffffff 00000000 0000000f
0 3 00000100 12345678 00000000
1 3 00000100 00000000 12345678
0 2 00000106 0000beef 00000000
1 6 00000106 00000000 ffffbeef
1 2 00000106 00000000 0000beef
0 1 00000103 000000a5 00000000
1 5 00000103 00000000 ffffffa5
1 1 00000102 00000000 00000034
1 3 00000100 00000000 a5345678
# same cache index, different tags
0 3 00000120 cafef00d 00000000
0 3 00000200 0badc0de 00000000
1 3 00000100 00000000 a5345678
1 3 00000120 00000000 cafef00d
1 3 00000200 00000000 0badc0de
# misaligned half loads and stores
1 6 00000101 00000000 00000000
0 2 00000121 0000ffff 00000000
1 3 00000120 00000000 cafef00d
1 3 00000104 00000000 beef0000
0 1 ffffffff 0000000a 00000000
1 1 ffffffff 00000000 0000000a
0 1 fffffffe 0000005c 00000000
2 0 00000000 00000000 0000005c
3 0 00000000 000000c3 00000000
1 5 fffffffd 00000000 ffffffc3
1 5 fffffffd 00000000 00000000

// File: ramio_top.f
ramio_pkg.sv
uarttx.sv
uartrx.sv
cache.sv
ramio.sv
burst_ram.sv
ramio_top.sv
ramio_top_props.sv
ramio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the ramio_top testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ramio_top_tb -f ramio_top.f -o ramio_top_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/ramio_top_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
  echo "testbench reported failure, see $log"
  exit 1
fi

echo "testbench run finished without failure"
exit 0
